/* mem_pkg.sv */
package mem_pkg;

    // Data path and address width
    localparam int xlen = 32;

    // Register file index width
    localparam int reg_addr_w = 5;

    // Data RAM geometry, in words
    localparam int ram_addr_w = 8;
    localparam int ram_depth  = 256;

    // Write-back control that rides along with each instruction
    typedef struct packed {
        logic                  mem_to_reg; // Loaded word goes to the register file
        logic                  reg_write;  // Register write requested
        logic [reg_addr_w-1:0] reg_dest;   // Destination register
    } wb_ctrl_t;

    // Word index of a byte address
    // Bits 1:0 select a byte inside the word and are dropped
    function automatic logic [ram_addr_w-1:0] word_index(input logic [xlen-1:0] byte_addr);
        return byte_addr[ram_addr_w+1:2];
    endfunction

    // Set when a byte address points at the start of a word
    function automatic logic is_word_aligned(input logic [xlen-1:0] byte_addr);
        return byte_addr[1:0] == 2'b00;
    endfunction

endpackage

/* ex_mem_if.sv */
`timescale 1ns/1ps

interface ex_mem_if;
    import mem_pkg::*;

    logic [xlen-1:0] alu_result;    // Address for loads and stores, ALU value otherwise
    logic [xlen-1:0] store_data;    // Word to be stored
    logic            mem_read;      // Load command
    logic            mem_write;     // Store command
    wb_ctrl_t        ctrl;          // Write-back control
    logic            pc_src;        // Branch taken
    logic [xlen-1:0] branch_target; // Branch destination

    // Execute side
    modport sender (
        output alu_result,
        output store_data,
        output mem_read,
        output mem_write,
        output ctrl,
        output pc_src,
        output branch_target
    );

    // Memory stage side
    modport receiver (
        input alu_result,
        input store_data,
        input mem_read,
        input mem_write,
        input ctrl,
        input pc_src,
        input branch_target
    );

endinterface

/* mem_wb_if.sv */
`timescale 1ns/1ps

interface mem_wb_if;
    import mem_pkg::*;

    // Both fields are already registered by the memory stage
    logic [xlen-1:0] alu_result; // ALU value of the instruction
    wb_ctrl_t        ctrl;       // Write-back control

    // Memory stage side
    modport sender (
        output alu_result,
        output ctrl
    );

    // Write-back stage side
    modport receiver (
        input alu_result,
        input ctrl
    );

endinterface

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                        clk,
    input  logic [mem_pkg::ram_addr_w-1:0] ram_addr,
    input  logic [mem_pkg::xlen-1:0]       ram_wdata,
    input  logic                        ram_we,
    output logic [mem_pkg::xlen-1:0]       ram_rdata
);
    import mem_pkg::*;

    // Word storage, contents start undefined
    logic [xlen-1:0] mem [ram_depth];

    // Synchronous write
    always_ff @(posedge clk)
    begin
        if (ram_we)
        begin
            mem[ram_addr] <= ram_wdata;
        end
    end

    // Registered read, data follows the address by one edge.
    // A read and a write to the same word at one edge return the old word.
    always_ff @(posedge clk)
    begin
        ram_rdata <= mem[ram_addr];
    end

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                           clk,
    input  logic                           rst,
    ex_mem_if.receiver                     ex,
    mem_wb_if.sender                       wb,
    output logic [mem_pkg::ram_addr_w-1:0] ram_addr,
    output logic [mem_pkg::xlen-1:0]       ram_wdata,
    output logic                           ram_we,
    output logic                           pc_src_out,
    output logic [mem_pkg::xlen-1:0]       branch_target_out
);
    import mem_pkg::*;

    logic [xlen-1:0] addr_q;       // ALU result, doubles as byte address
    logic [xlen-1:0] store_data_q; // Data for a pending store
    logic            store_q;      // Registered store command
    wb_ctrl_t        ctrl_q;       // Control for the write-back stage

    // Memory-access pipeline register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            addr_q            <= '0;
            store_data_q      <= '0;
            store_q           <= 1'b0;
            ctrl_q            <= '0;
            pc_src_out        <= 1'b0;
            branch_target_out <= '0;
        end
        else
        begin
            addr_q            <= ex.alu_result;
            store_data_q      <= ex.store_data;
            store_q           <= ex.mem_write;
            ctrl_q            <= ex.ctrl;
            pc_src_out        <= ex.pc_src;        // Back to fetch
            branch_target_out <= ex.branch_target;
        end
    end

    // RAM side, all from the register
    assign ram_addr  = word_index(addr_q);
    assign ram_wdata = store_data_q;
    assign ram_we    = store_q;

    // On to write-back
    assign wb.alu_result = addr_q;
    assign wb.ctrl       = ctrl_q;

    // One instruction cannot both load and store
    a_no_load_and_store: assert property (
        @(posedge clk) disable iff (rst)
        !(ex.mem_read && ex.mem_write)
    ) else $error("mem_stage: load and store requested together");

    // Only whole words are accessed
    a_word_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (ex.mem_read || ex.mem_write) |-> is_word_aligned(ex.alu_result)
    ) else $error("mem_stage: unaligned address %h", ex.alu_result);

    // A load must hand its word to write-back
    a_load_writes_back: assert property (
        @(posedge clk) disable iff (rst)
        ex.mem_read |=> wb.ctrl.mem_to_reg
    ) else $error("mem_stage: load issued without mem_to_reg");

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic                           clk,
    input  logic                           rst,
    mem_wb_if.receiver                     mw,
    input  logic [mem_pkg::xlen-1:0]       ram_rdata,
    output logic                           wb_en,
    output logic [mem_pkg::reg_addr_w-1:0] wb_dest,
    output logic [mem_pkg::xlen-1:0]       wb_data
);
    import mem_pkg::*;

    wb_ctrl_t        ctrl_q;  // Control of the instruction being retired
    logic [xlen-1:0] alu_q;   // Its ALU result

    // Lines up with the RAM read data
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ctrl_q <= '0;
            alu_q  <= '0;
        end
        else
        begin
            ctrl_q <= mw.ctrl;
            alu_q  <= mw.alu_result;
        end
    end

    // Loaded word or ALU value
    assign wb_data = ctrl_q.mem_to_reg ? ram_rdata : alu_q;
    assign wb_dest = ctrl_q.reg_dest;

    // Register 0 always reads as zero, so writes to it are dropped
    assign wb_en = ctrl_q.reg_write && (ctrl_q.reg_dest != '0);

    // A load result that is never written is a decode fault upstream
    a_mem_to_reg_needs_write: assert property (
        @(posedge clk) disable iff (rst)
        mw.ctrl.mem_to_reg |-> mw.ctrl.reg_write
    ) else $error("writeback_stage: mem_to_reg set without reg_write");

endmodule

/* mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                           clk,
    input  logic                           rst,

    // From the execute stage
    input  logic [mem_pkg::xlen-1:0]       alu_result,
    input  logic [mem_pkg::xlen-1:0]       store_data,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic                           mem_to_reg,
    input  logic                           reg_write,
    input  logic [mem_pkg::reg_addr_w-1:0] reg_dest,
    input  logic                           pc_src,
    input  logic [mem_pkg::xlen-1:0]       branch_target,

    // To fetch
    output logic                           pc_src_out,
    output logic [mem_pkg::xlen-1:0]       branch_target_out,

    // To the register file
    output logic                           wb_en,
    output logic [mem_pkg::reg_addr_w-1:0] wb_dest,
    output logic [mem_pkg::xlen-1:0]       wb_data
);
    import mem_pkg::*;

    ex_mem_if ex_bus ();
    mem_wb_if mw_bus ();

    logic [ram_addr_w-1:0] ram_addr;
    logic [xlen-1:0]       ram_wdata;
    logic                  ram_we;
    logic [xlen-1:0]       ram_rdata;

    // Execute side of the request bus
    assign ex_bus.alu_result      = alu_result;
    assign ex_bus.store_data      = store_data;
    assign ex_bus.mem_read        = mem_read;
    assign ex_bus.mem_write       = mem_write;
    assign ex_bus.ctrl.mem_to_reg = mem_to_reg;
    assign ex_bus.ctrl.reg_write  = reg_write;
    assign ex_bus.ctrl.reg_dest   = reg_dest;
    assign ex_bus.pc_src          = pc_src;
    assign ex_bus.branch_target   = branch_target;

    mem_stage u_mem_stage (
        .clk               (clk),
        .rst               (rst),
        .ex                (ex_bus.receiver),
        .wb                (mw_bus.sender),
        .ram_addr          (ram_addr),
        .ram_wdata         (ram_wdata),
        .ram_we            (ram_we),
        .pc_src_out        (pc_src_out),
        .branch_target_out (branch_target_out)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata)
    );

    writeback_stage u_writeback_stage (
        .clk       (clk),
        .rst       (rst),
        .mw        (mw_bus.receiver),
        .ram_rdata (ram_rdata),
        .wb_en     (wb_en),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data)
    );

endmodule

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int clk_period = 20;
    localparam int n_words    = 32;   // Stores, then as many loads
    localparam int n_alu      = 40;
    localparam int n_pairs    = 16;   // Store then load of the same word
    localparam int n_branch   = 30;
    localparam int n_mix      = 300;
    localparam int n_tests    = 6;    // Tests that drain the pipeline
    localparam int total_instr = 2 * n_words + n_alu + 2 * n_pairs + n_branch
                               + n_mix + 3 + 2 * n_tests + 3;

    logic                  clk;
    logic                  rst;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       store_data;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  reg_write;
    logic [reg_addr_w-1:0] reg_dest;
    logic                  pc_src;
    logic [xlen-1:0]       branch_target;
    logic                  pc_src_out;
    logic [xlen-1:0]       branch_target_out;
    logic                  wb_en;
    logic [reg_addr_w-1:0] wb_dest;
    logic [xlen-1:0]       wb_data;

    integer seed = 32'h33f475e1;

    // Reference model
    logic [xlen-1:0] model_ram [ram_depth];
    bit              written [ram_depth];
    logic [7:0]      written_list [$];     // Word indices that hold data
    logic            exp_en_q [$];         // Write-back delay line
    logic [4:0]      exp_dest_q [$];
    logic [31:0]     exp_data_q [$];
    logic            exp_pcs_q [$];        // Branch delay line
    logic [31:0]     exp_bt_q [$];

    int errors;
    int test_start_errors;
    int tests_passed;
    int tests_failed;

    mem_subsystem_top DUT (
        .clk               (clk),
        .rst               (rst),
        .alu_result        (alu_result),
        .store_data        (store_data),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_to_reg        (mem_to_reg),
        .reg_write         (reg_write),
        .reg_dest          (reg_dest),
        .pc_src            (pc_src),
        .branch_target     (branch_target),
        .pc_src_out        (pc_src_out),
        .branch_target_out (branch_target_out),
        .wb_en             (wb_en),
        .wb_dest           (wb_dest),
        .wb_data           (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #((total_instr + 50) * clk_period);
        $display("Watchdog expired at %0t, the tests did not finish in time", $time);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Random upper bits, word index in bits 9:2, byte offset zero
    function automatic logic [31:0] aligned_addr(input logic [7:0] idx);
        logic [31:0] addr;
        addr = rand_word();
        addr[9:2] = idx;
        addr[1:0] = 2'b00;
        return addr;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // One instruction per clock with outputs checked at the falling edge
    task automatic issue(input logic [31:0] alu, input logic [31:0] sdata, input logic rd,
                         input logic wr, input logic m2r, input logic rw,
                         input logic [4:0] dest, input logic pcs, input logic [31:0] bt);
        logic [7:0] idx;
        @(posedge clk);
        alu_result    <= alu;
        store_data    <= sdata;
        mem_read      <= rd;
        mem_write     <= wr;
        mem_to_reg    <= m2r;
        reg_write     <= rw;
        reg_dest      <= dest;
        pc_src        <= pcs;
        branch_target <= bt;
        idx = alu[9:2];
        exp_en_q.push_back(rw && (dest != 5'd0));
        exp_dest_q.push_back(dest);
        exp_data_q.push_back(m2r ? model_ram[idx] : alu); // Earlier stores already applied
        exp_pcs_q.push_back(pcs);
        exp_bt_q.push_back(bt);
        if (wr)
        begin
            model_ram[idx] = sdata;
            if (!written[idx])
            begin
                written[idx] = 1'b1;
                written_list.push_back(idx);
            end
        end
        @(negedge clk);
        if (exp_pcs_q.size() > 1)          // Branch lags by one edge
        begin
            check_value("pc_src_out", exp_pcs_q.pop_front(), pc_src_out);
            check_value("branch_target_out", exp_bt_q.pop_front(), branch_target_out);
        end
        if (exp_en_q.size() > 2)           // Write-back lags by two edges
        begin
            check_value("wb_en", exp_en_q.pop_front(), wb_en);
            check_value("wb_dest", exp_dest_q.pop_front(), wb_dest);
            check_value("wb_data", exp_data_q.pop_front(), wb_data);
        end
    endtask

    task automatic store_word(input logic [7:0] idx, input logic [31:0] data);
        issue(aligned_addr(idx), data, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 1'b0, 32'd0);
    endtask

    task automatic load_word(input logic [7:0] idx, input logic [4:0] dest);
        issue(aligned_addr(idx), rand_word(), 1'b1, 1'b0, 1'b1, 1'b1, dest, 1'b0, 32'd0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) issue(32'd0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 1'b0, 32'd0);
    endtask

    task automatic end_test(input string name);
        idle_cycles(2);                    // Flush the two register levels
        if (errors == test_start_errors)
        begin
            tests_passed++;
            $display("Test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d mismatches", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial
    begin
        logic [7:0]  idx;
        logic [31:0] data;
        logic        rw;
        logic [4:0]  dest;
        int unsigned kind;
        rst           = 1'b1;
        alu_result    = '0;
        store_data    = '0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_to_reg    = 1'b0;
        reg_write     = 1'b0;
        reg_dest      = '0;
        pc_src        = 1'b0;
        branch_target = '0;
        errors = 0;
        test_start_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        // Reset state stands in for the first two slots
        repeat (2)
        begin
            exp_en_q.push_back(1'b0);
            exp_dest_q.push_back(5'd0);
            exp_data_q.push_back(32'd0);
        end
        exp_pcs_q.push_back(1'b0);
        exp_bt_q.push_back(32'd0);

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("wb_en", 32'd0, wb_en);
        check_value("pc_src_out", 32'd0, pc_src_out);
        end_test("reset");

        for (int i = 0; i < n_words; i++)
        begin
            store_word(rand_word(), rand_word());
        end
        for (int i = 0; i < n_words; i++)
        begin
            idx = written_list[rand_below(written_list.size())];
            load_word(idx, 5'd1 + rand_below(31));
        end
        end_test("store_load");

        for (int i = 0; i < n_alu; i++)
        begin
            issue(rand_word(), rand_word(), 1'b0, 1'b0, 1'b0, 1'b1, 5'd1 + rand_below(31),
                  1'b0, 32'd0);
        end
        end_test("alu_only");

        for (int i = 0; i < n_pairs; i++)
        begin
            idx = rand_word();
            store_word(idx, rand_word());
            load_word(idx, 5'd1 + rand_below(31)); // Must see the word just stored
        end
        end_test("store_then_load");

        for (int i = 0; i < n_branch; i++)
        begin
            issue(rand_word(), 32'd0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, rand_word(), rand_word());
        end
        end_test("branch");

        // No write without reg_write, none to register 0
        issue(rand_word(), 32'd0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd7, 1'b0, 32'd0);
        issue(rand_word(), 32'd0, 1'b0, 1'b0, 1'b0, 1'b1, 5'd0, 1'b0, 32'd0);
        load_word(written_list[0], 5'd0);
        for (int i = 0; i < n_mix; i++)
        begin
            kind = rand_below(3);
            rw   = rand_word();
            dest = (rand_below(8) == 0) ? 5'd0 : rand_word();
            if (kind == 1)
            begin
                data = rand_word();
                issue(aligned_addr(rand_word()), data, 1'b0, 1'b1, 1'b0, rw, dest,
                      rand_word(), rand_word());
            end
            else if (kind == 2)
            begin
                idx = written_list[rand_below(written_list.size())];
                issue(aligned_addr(idx), rand_word(), 1'b1, 1'b0, 1'b1, 1'b1, dest,
                      rand_word(), rand_word());
            end
            else
            begin
                issue(rand_word(), rand_word(), 1'b0, 1'b0, 1'b0, rw, dest,
                      rand_word(), rand_word());
            end
        end
        end_test("random_mix");

        $display("Tests ok: %0d, tests with errors: %0d, mismatches: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* list.f */
mem_pkg.sv
ex_mem_if.sv
mem_wb_if.sv
data_ram.sv
mem_stage.sv
writeback_stage.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv
